//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- src.f
+incdir+tests
verilog/ex_pkg.sv
verilog/imm_gen.sv
verilog/ex_alu.sv
verilog/ex_control.sv
verilog/mem_req_reg.sv
verilog/ex_stage.sv
tests/tb_ex_stage.sv

//--- tests/ex_vectors.svh
// Columns: name, inst, pc, rs1, rs2, br_taken, check alu_out, alu_out, flush, br_suc,
// csr_en, csr_wdata, mem_wmask, mem_wdata, enables {imem, dmem, bios, io}
task automatic load_vectors();
    add_row("ADD", enc_r(7'h00, FNC_ADD_SUB), 32'h1000, 32'h1234_5678, 32'h1111, 1'b0,
            1'b1, 32'h1234_6789, 1'b0, 1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    add_row("SUB", enc_r(7'h20, FNC_ADD_SUB), 32'h1000, 32'h10, 32'h20, 1'b0,
            1'b1, 32'hffff_fff0, 1'b0, 1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    add_row("SRA", enc_r(7'h20, FNC_SRL_SRA), 32'h1000, 32'h8000_0000, 32'h4, 1'b0,
            1'b1, 32'hf800_0000, 1'b0, 1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    add_row("SLTU", enc_r(7'h00, FNC_SLTU), 32'h1000, 32'h1, 32'hffff_ffff, 1'b0,
            1'b1, 32'h1, 1'b0, 1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    add_row("ADDI", enc_i(12'hfff, 5'd1, FNC_ADD_SUB, OPC_ARI_ITYPE), 32'h1000, 32'h100, 32'h0,
            1'b0, 1'b1, 32'hff, 1'b0, 1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    add_row("SRAI", enc_i(12'h408, 5'd1, FNC_SRL_SRA, OPC_ARI_ITYPE), 32'h1000, 32'hf000_0000,
            32'h0, 1'b0, 1'b1, 32'hfff0_0000, 1'b0, 1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    add_row("SLTIU", enc_i(12'h005, 5'd1, FNC_SLTU, OPC_ARI_ITYPE), 32'h1000, 32'h3, 32'h0,
            1'b0, 1'b1, 32'h1, 1'b0, 1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    add_row("LUI", enc_u(20'habcde, OPC_LUI), 32'h1000, 32'h55, 32'h66, 1'b0,
            1'b1, 32'habcd_e000, 1'b0, 1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    add_row("AUIPC", enc_u(20'h00001, OPC_AUIPC), 32'h1000, 32'h55, 32'h66, 1'b0,
            1'b1, 32'h2000, 1'b0, 1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    // Branches at pc 0x1000, offset +16 except BLT at -8
    add_row("BEQ hit", enc_b(13'h0010, FNC_BEQ), 32'h1000, 32'h5, 32'h5, 1'b1,
            1'b0, 32'h0, 1'b0, 1'b1, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    add_row("BEQ miss", enc_b(13'h0010, FNC_BEQ), 32'h1000, 32'h5, 32'h5, 1'b0,
            1'b1, 32'h1010, 1'b1, 1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    add_row("BNE hit", enc_b(13'h0010, FNC_BNE), 32'h1000, 32'h5, 32'h5, 1'b0,
            1'b0, 32'h0, 1'b0, 1'b1, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    add_row("BNE miss", enc_b(13'h0010, FNC_BNE), 32'h1000, 32'h5, 32'h5, 1'b1,
            1'b1, 32'h1004, 1'b1, 1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    add_row("BLT hit", enc_b(13'h1ff8, FNC_BLT), 32'h1000, 32'hffff_ffff, 32'h1, 1'b1,
            1'b0, 32'h0, 1'b0, 1'b1, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    add_row("BLT miss", enc_b(13'h1ff8, FNC_BLT), 32'h1000, 32'hffff_ffff, 32'h1, 1'b0,
            1'b1, 32'h0ff8, 1'b1, 1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    add_row("BGE hit", enc_b(13'h0010, FNC_BGE), 32'h1000, 32'hffff_ffff, 32'h1, 1'b0,
            1'b0, 32'h0, 1'b0, 1'b1, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    add_row("BGE miss", enc_b(13'h0010, FNC_BGE), 32'h1000, 32'hffff_ffff, 32'h1, 1'b1,
            1'b1, 32'h1004, 1'b1, 1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    add_row("BLTU hit", enc_b(13'h0010, FNC_BLTU), 32'h1000, 32'hffff_ffff, 32'h1, 1'b0,
            1'b0, 32'h0, 1'b0, 1'b1, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    add_row("BLTU miss", enc_b(13'h0010, FNC_BLTU), 32'h1000, 32'hffff_ffff, 32'h1, 1'b1,
            1'b1, 32'h1004, 1'b1, 1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    add_row("BGEU hit", enc_b(13'h0010, FNC_BGEU), 32'h1000, 32'hffff_ffff, 32'h1, 1'b1,
            1'b0, 32'h0, 1'b0, 1'b1, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    add_row("BGEU miss", enc_b(13'h0010, FNC_BGEU), 32'h1000, 32'hffff_ffff, 32'h1, 1'b0,
            1'b1, 32'h1010, 1'b1, 1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    add_row("JALR", enc_i(12'h004, 5'd1, 3'b000, OPC_JALR), 32'h1000, 32'h2000, 32'h0, 1'b0,
            1'b1, 32'h2004, 1'b1, 1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 4'h0);
    // LW is funct3 3'b010
    add_row("LW io", enc_i(12'h004, 5'd1, 3'b010, OPC_LOAD), 32'h1000, 32'h8000_0000, 32'h0,
            1'b0, 1'b1, 32'h8000_0004, 1'b0, 1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 4'b0001);
    add_row("LW bios", enc_i(12'h010, 5'd1, 3'b010, OPC_LOAD), 32'h1000, 32'h4000_0000, 32'h0,
            1'b0, 1'b1, 32'h4000_0010, 1'b0, 1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 4'b0010);
    add_row("LW dmem", enc_i(12'h020, 5'd1, 3'b010, OPC_LOAD), 32'h1000, 32'h1000_0000, 32'h0,
            1'b0, 1'b1, 32'h1000_0020, 1'b0, 1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 4'b0100);
    add_row("LW mirror", enc_i(12'h008, 5'd1, 3'b010, OPC_LOAD), 32'h1000, 32'h3000_0000,
            32'h0, 1'b0, 1'b1, 32'h3000_0008, 1'b0, 1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 4'b0100);
    add_row("SB dmem +1", enc_s(12'h001, FNC_SB), 32'h1000, 32'h1000_0000, 32'ha1b2_c3d4,
            1'b0, 1'b1, 32'h1000_0001, 1'b0, 1'b0, 1'b0, 32'h0, 4'b0010, 32'h0000_d400, 4'b0100);
    add_row("SB io +3", enc_s(12'h003, FNC_SB), 32'h1000, 32'h8000_0000, 32'ha1b2_c3d4,
            1'b0, 1'b1, 32'h8000_0003, 1'b0, 1'b0, 1'b0, 32'h0, 4'b1000, 32'hd400_0000, 4'b0001);
    add_row("SH imem bios", enc_s(12'h002, FNC_SH), 32'h4000_0000, 32'h2000_0000, 32'ha1b2_c3d4,
            1'b0, 1'b1, 32'h2000_0002, 1'b0, 1'b0, 1'b0, 32'h0, 4'b1100, 32'hc3d4_0000, 4'b1000);
    add_row("SH imem user", enc_s(12'h000, FNC_SH), 32'h1000, 32'h2000_0000, 32'ha1b2_c3d4,
            1'b0, 1'b1, 32'h2000_0000, 1'b0, 1'b0, 1'b0, 32'h0, 4'b0011, 32'h0000_c3d4, 4'b0000);
    add_row("SW mirror", enc_s(12'h100, FNC_SW), 32'h4000_0000, 32'h3000_0000, 32'ha1b2_c3d4,
            1'b0, 1'b1, 32'h3000_0100, 1'b0, 1'b0, 1'b0, 32'h0, 4'b1111, 32'ha1b2_c3d4, 4'b1100);
    add_row("SW dmem -12", enc_s(12'hff4, FNC_SW), 32'h1000, 32'h1000_0010, 32'h1357_9bdf,
            1'b0, 1'b1, 32'h1000_0004, 1'b0, 1'b0, 1'b0, 32'h0, 4'b1111, 32'h1357_9bdf, 4'b0100);
    add_row("CSRRW", enc_i(12'h340, 5'd1, FNC_CSRRW, OPC_CSR), 32'h1000, 32'hdead_beef, 32'h0,
            1'b0, 1'b0, 32'h0, 1'b0, 1'b0, 1'b1, 32'hdead_beef, 4'h0, 32'h0, 4'h0);
    add_row("CSRRWI", enc_i(12'h340, 5'h1b, FNC_CSRRWI, OPC_CSR), 32'h1000, 32'hdead_beef,
            32'h0, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0, 1'b1, 32'h0000_001b, 4'h0, 32'h0, 4'h0);
endtask

//--- tests/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage;
    import ex_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic        br_taken;
        logic        chk_alu;
        logic [31:0] alu_out;
        logic        flush;
        logic        br_suc;
        logic        csr_en;
        logic [31:0] csr_wdata;
        logic [3:0]  wmask;
        logic [31:0] wdata;
        logic [3:0]  en;
    } vec_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst;
    logic [31:0] pc;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic        br_taken;
    logic [31:0] alu_out;
    logic        flush;
    logic        br_suc;
    logic        br_inst;
    logic        csr_en;
    logic [31:0] csr_wdata;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wmask;
    logic        imem_en;
    logic        dmem_en;
    logic        bios_en;
    logic        io_en;

    vec_t  vectors[$];
    string names[$];
    int    errors;
    int    passed;
    int    failed;
    int    cycle_count = 0;
    int    cycle_limit = 0;

    ex_stage dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst      (inst),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .br_taken  (br_taken),
        .alu_out   (alu_out),
        .flush     (flush),
        .br_suc    (br_suc),
        .br_inst   (br_inst),
        .csr_en    (csr_en),
        .csr_wdata (csr_wdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wmask (mem_wmask),
        .imem_en   (imem_en),
        .dmem_en   (dmem_en),
        .bios_en   (bios_en),
        .io_en     (io_en)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Run timed out after %0d cycles", cycle_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Instruction encoders with rd fixed at x3
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3);
        inst_t w;
        w.r_fmt.funct7 = f7;
        w.r_fmt.rs2    = 5'd2;
        w.r_fmt.rs1    = 5'd1;
        w.r_fmt.funct3 = f3;
        w.r_fmt.rd     = 5'd3;
        w.r_fmt.opcode = {OPC_ARI_RTYPE, 2'b11};
        return w;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1f,
                                          input logic [2:0] f3, input logic [4:0] opc);
        inst_t w;
        w.i_fmt.imm    = imm;
        w.i_fmt.rs1    = rs1f;
        w.i_fmt.funct3 = f3;
        w.i_fmt.rd     = 5'd3;
        w.i_fmt.opcode = {opc, 2'b11};
        return w;
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [2:0] f3);
        inst_t w;
        w.s_fmt.imm_hi = imm[11:5];
        w.s_fmt.rs2    = 5'd2;
        w.s_fmt.rs1    = 5'd1;
        w.s_fmt.funct3 = f3;
        w.s_fmt.imm_lo = imm[4:0];
        w.s_fmt.opcode = {OPC_STORE, 2'b11};
        return w;
    endfunction

    // Branch offset bits 12 and 10:5 high, 4:1 and 11 low
    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [2:0] f3);
        inst_t w;
        w.s_fmt.imm_hi = {off[12], off[10:5]};
        w.s_fmt.rs2    = 5'd2;
        w.s_fmt.rs1    = 5'd1;
        w.s_fmt.funct3 = f3;
        w.s_fmt.imm_lo = {off[4:1], off[11]};
        w.s_fmt.opcode = {OPC_BRANCH, 2'b11};
        return w;
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] opc);
        inst_t w;
        w.u_fmt.imm    = imm;
        w.u_fmt.rd     = 5'd3;
        w.u_fmt.opcode = {opc, 2'b11};
        return w;
    endfunction

    task automatic add_row(input string name, input logic [31:0] inst_v,
                           input logic [31:0] pc_v, input logic [31:0] rs1_v,
                           input logic [31:0] rs2_v, input logic taken_v,
                           input logic chk_alu_v, input logic [31:0] alu_v,
                           input logic flush_v, input logic suc_v, input logic csr_en_v,
                           input logic [31:0] csr_v, input logic [3:0] wmask_v,
                           input logic [31:0] wdata_v, input logic [3:0] en_v);
        vec_t v;
        v.inst      = inst_v;
        v.pc        = pc_v;
        v.rs1       = rs1_v;
        v.rs2       = rs2_v;
        v.br_taken  = taken_v;
        v.chk_alu   = chk_alu_v;
        v.alu_out   = alu_v;
        v.flush     = flush_v;
        v.br_suc    = suc_v;
        v.csr_en    = csr_en_v;
        v.csr_wdata = csr_v;
        v.wmask     = wmask_v;
        v.wdata     = wdata_v;
        v.en        = en_v;
        vectors.push_back(v);
        names.push_back(name);
    endtask

    task automatic check_val(input string name, input logic [31:0] seen,
                             input logic [31:0] expected);
        if (seen !== expected) begin
            errors++;
            $display("ERR t=%0t %s seen=%h expected=%h", $time, name, seen, expected);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            passed++;
            $display("test %-14s ok", name);
        end else begin
            failed++;
            $display("test %-14s FAILED", name);
        end
    endtask

    task automatic check_reset();
        int errs_before;
        errs_before = errors;
        check_val("mem_wmask", 32'(mem_wmask), 32'h0);
        check_val("mem_en", 32'({imem_en, dmem_en, bios_en, io_en}), 32'h0);
        check_val("mem_addr", mem_addr, 32'h0);
        check_val("mem_wdata", mem_wdata, 32'h0);
        report_test("reset", errs_before);
    endtask

    task automatic run_row(input int idx);
        vec_t v;
        int   errs_before;
        v = vectors[idx];
        errs_before = errors;
        @(negedge clk);
        inst     = v.inst;
        pc       = v.pc;
        rs1      = v.rs1;
        rs2      = v.rs2;
        br_taken = v.br_taken;
        // Combinational outputs just before the capturing edge
        #(CLK_PERIOD / 2 - 2);
        if (v.chk_alu) begin
            check_val("alu_out", alu_out, v.alu_out);
        end
        check_val("flush", 32'(flush), 32'(v.flush));
        check_val("br_suc", 32'(br_suc), 32'(v.br_suc));
        // Only conditional branches are flagged
        check_val("br_inst", 32'(br_inst), 32'(v.inst[6:2] == OPC_BRANCH));
        check_val("csr_en", 32'(csr_en), 32'(v.csr_en));
        if (v.csr_en) begin
            check_val("csr_wdata", csr_wdata, v.csr_wdata);
        end
        @(posedge clk);
        #1;
        check_val("mem_wmask", 32'(mem_wmask), 32'(v.wmask));
        check_val("mem_en", 32'({imem_en, dmem_en, bios_en, io_en}), 32'(v.en));
        if (v.wmask != 4'h0) begin
            check_val("mem_wdata", mem_wdata, v.wdata);
        end
        if (v.chk_alu) begin
            check_val("mem_addr", mem_addr, v.alu_out);
        end
        report_test(names[idx], errs_before);
    endtask

    `include "ex_vectors.svh"

    initial begin
        rst_n    = 1'b0;
        inst     = 32'h0000_0013;
        pc       = 32'h0;
        rs1      = 32'h0;
        rs2      = 32'h0;
        br_taken = 1'b0;
        errors   = 0;
        passed   = 0;
        failed   = 0;
        load_vectors();
        cycle_limit = vectors.size() * 4 + 20;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        check_reset();
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < vectors.size(); i++) begin
            run_row(i);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
                 passed + failed, passed, failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    input  logic [31:0]                  a,
    input  logic [31:0]                  b,
    input  logic [ex_pkg::ALU_SEL_W-1:0] alu_sel,
    input  logic [31:0]                  rs1,
    input  logic [31:0]                  rs2,
    input  logic                         brun,
    output logic [31:0]                  result,
    output logic                         breq,
    output logic                         brlt
);
    import ex_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_sel)
            ALU_ADD:      result = a + b;
            ALU_SUB:      result = a - b;
            ALU_AND:      result = a & b;
            ALU_OR:       result = a | b;
            ALU_XOR:      result = a ^ b;
            ALU_SLL:      result = a << shamt;
            ALU_SRL:      result = a >> shamt;
            ALU_SRA:      result = $signed(a) >>> shamt;
            ALU_SLT:      result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:     result = {31'b0, a < b};
            ALU_A_PLUS_4: result = a + 32'd4;
            ALU_BSEL:     result = b;
            default:      result = a + b;
        endcase
    end

    // Branch comparator works on the register operands
    assign breq = (rs1 == rs2);
    assign brlt = brun ? (rs1 < rs2) : ($signed(rs1) < $signed(rs2));

endmodule

//--- verilog/ex_control.sv
`timescale 1ns/1ps

module ex_control (
    input  ex_pkg::inst_t                 inst,
    input  logic [31:0]                   addr,
    input  logic [31:0]                   pc,
    input  logic                          breq,
    input  logic                          brlt,
    input  logic                          br_taken,
    output logic [ex_pkg::ALU_SEL_W-1:0]  alu_sel,
    output logic [1:0]                    size,
    output logic                          brun,
    output logic                          a_sel,
    output logic                          b_sel,
    output logic                          csr_mux_sel,
    output logic                          csr_en,
    output logic                          br_suc,
    output logic                          flush,
    output logic                          br_inst,
    output logic                          imem_en,
    output logic                          dmem_en,
    output logic                          bios_en,
    output logic                          io_en
);
    import ex_pkg::*;

    logic [4:0] opcode5;
    logic [2:0] funct3;
    logic       alt;
    logic [3:0] region;
    logic       br_cond;

    assign opcode5 = inst.r_fmt.opcode[6:2];
    assign funct3  = inst.r_fmt.funct3;
    assign alt     = inst.r_fmt.funct7[5];
    assign region  = addr[31:28];

    always_comb begin
        alu_sel     = ALU_DONT_CARE;
        size        = MEM_SIZE_NONE;
        brun        = BRUN_DONT_CARE;
        a_sel       = A_DONT_CARE;
        b_sel       = B_DONT_CARE;
        csr_mux_sel = CSR_DONT_CARE;
        csr_en      = 1'b0;
        br_suc      = 1'b0;
        flush       = 1'b0;
        br_inst     = 1'b0;
        imem_en     = 1'b0;
        dmem_en     = 1'b0;
        bios_en     = 1'b0;
        io_en       = 1'b0;
        br_cond     = 1'b0;

        case (opcode5)
            OPC_ARI_RTYPE, OPC_ARI_ITYPE: begin
                a_sel = A_REG;
                b_sel = (opcode5 == OPC_ARI_RTYPE) ? B_REG : B_IMM;
                case (funct3)
                    // Only R-type uses bit 30 to pick SUB
                    FNC_ADD_SUB: alu_sel = (opcode5 == OPC_ARI_RTYPE && alt == FNC2_SUB) ?
                                           ALU_SUB : ALU_ADD;
                    FNC_SLL:     alu_sel = ALU_SLL;
                    FNC_SLT:     alu_sel = ALU_SLT;
                    FNC_SLTU:    alu_sel = ALU_SLTU;
                    FNC_XOR:     alu_sel = ALU_XOR;
                    FNC_OR:      alu_sel = ALU_OR;
                    FNC_AND:     alu_sel = ALU_AND;
                    FNC_SRL_SRA: alu_sel = (alt == FNC2_SRA) ? ALU_SRA : ALU_SRL;
                    default:     alu_sel = ALU_DONT_CARE;
                endcase
            end
            OPC_LOAD: begin
                a_sel   = A_REG;
                b_sel   = B_IMM;
                alu_sel = ALU_ADD;
                case (region)
                    ADDR_IO:     io_en = 1'b1;
                    ADDR_BIOS:   bios_en = 1'b1;
                    ADDR_DMEM:   dmem_en = 1'b1;
                    ADDR_MIRROR: dmem_en = 1'b1;
                    default:     dmem_en = 1'b0;
                endcase
            end
            OPC_STORE: begin
                a_sel   = A_REG;
                b_sel   = B_IMM;
                alu_sel = ALU_ADD;
                // IMEM is writable only while running from BIOS
                case (region)
                    ADDR_IO:   io_en = 1'b1;
                    ADDR_DMEM: dmem_en = 1'b1;
                    ADDR_IMEM: imem_en = pc[30];
                    ADDR_MIRROR: begin
                        imem_en = pc[30];
                        dmem_en = 1'b1;
                    end
                    default:   dmem_en = 1'b0;
                endcase
                case (funct3)
                    FNC_SB:  size = MEM_SIZE_BYTE;
                    FNC_SH:  size = MEM_SIZE_HALF;
                    FNC_SW:  size = MEM_SIZE_WORD;
                    default: size = MEM_SIZE_NONE;
                endcase
            end
            OPC_BRANCH: begin
                br_inst = 1'b1;
                a_sel   = A_PC;
                b_sel   = B_IMM;
                // Actual outcome of the compare
                case (funct3)
                    FNC_BEQ: begin
                        brun    = 1'b0;
                        br_cond = breq;
                    end
                    FNC_BNE: begin
                        brun    = 1'b0;
                        br_cond = !breq;
                    end
                    FNC_BLT: begin
                        brun    = 1'b0;
                        br_cond = brlt;
                    end
                    FNC_BGE: begin
                        brun    = 1'b0;
                        br_cond = !brlt;
                    end
                    FNC_BLTU: begin
                        brun    = 1'b1;
                        br_cond = brlt;
                    end
                    FNC_BGEU: begin
                        brun    = 1'b1;
                        br_cond = !brlt;
                    end
                    default: br_cond = 1'b0;
                endcase
                if (br_cond == br_taken) begin
                    br_suc = 1'b1;
                end else begin
                    // Mispredict, redirect to the real next pc
                    flush   = 1'b1;
                    alu_sel = br_cond ? ALU_ADD : ALU_A_PLUS_4;
                end
            end
            OPC_JAL: begin
                a_sel   = A_PC;
                b_sel   = B_IMM;
                alu_sel = ALU_ADD;
            end
            OPC_JALR: begin
                a_sel   = A_REG;
                b_sel   = B_IMM;
                alu_sel = ALU_ADD;
                flush   = 1'b1;
            end
            OPC_LUI: begin
                a_sel   = A_PC;
                b_sel   = B_IMM;
                alu_sel = ALU_BSEL;
            end
            OPC_AUIPC: begin
                a_sel   = A_PC;
                b_sel   = B_IMM;
                alu_sel = ALU_ADD;
            end
            OPC_CSR: begin
                csr_en = 1'b1;
                case (funct3)
                    FNC_CSRRW:  csr_mux_sel = CSR_RD1;
                    FNC_CSRRWI: csr_mux_sel = CSR_IMM;
                    default:    csr_mux_sel = CSR_DONT_CARE;
                endcase
            end
            default: begin
                alu_sel = ALU_DONT_CARE;
            end
        endcase
    end

endmodule

//--- verilog/ex_pkg.sv
package ex_pkg;

    // Major opcodes, inst[6:2]
    localparam logic [4:0] OPC_ARI_RTYPE = 5'b01100;
    localparam logic [4:0] OPC_ARI_ITYPE = 5'b00100;
    localparam logic [4:0] OPC_LOAD      = 5'b00000;
    localparam logic [4:0] OPC_STORE     = 5'b01000;
    localparam logic [4:0] OPC_BRANCH    = 5'b11000;
    localparam logic [4:0] OPC_JAL       = 5'b11011;
    localparam logic [4:0] OPC_JALR      = 5'b11001;
    localparam logic [4:0] OPC_LUI       = 5'b01101;
    localparam logic [4:0] OPC_AUIPC     = 5'b00101;
    localparam logic [4:0] OPC_CSR       = 5'b11100;

    localparam logic [2:0] FNC_ADD_SUB = 3'b000;
    localparam logic [2:0] FNC_SLL     = 3'b001;
    localparam logic [2:0] FNC_SLT     = 3'b010;
    localparam logic [2:0] FNC_SLTU    = 3'b011;
    localparam logic [2:0] FNC_XOR     = 3'b100;
    localparam logic [2:0] FNC_SRL_SRA = 3'b101;
    localparam logic [2:0] FNC_OR      = 3'b110;
    localparam logic [2:0] FNC_AND     = 3'b111;

    localparam logic [2:0] FNC_SB = 3'b000;
    localparam logic [2:0] FNC_SH = 3'b001;
    localparam logic [2:0] FNC_SW = 3'b010;

    localparam logic [2:0] FNC_BEQ  = 3'b000;
    localparam logic [2:0] FNC_BNE  = 3'b001;
    localparam logic [2:0] FNC_BLT  = 3'b100;
    localparam logic [2:0] FNC_BGE  = 3'b101;
    localparam logic [2:0] FNC_BLTU = 3'b110;
    localparam logic [2:0] FNC_BGEU = 3'b111;

    localparam logic [2:0] FNC_CSRRW  = 3'b001;
    localparam logic [2:0] FNC_CSRRWI = 3'b101;

    // Value of inst[30]
    localparam logic FNC2_ADD = 1'b0;
    localparam logic FNC2_SUB = 1'b1;
    localparam logic FNC2_SRL = 1'b0;
    localparam logic FNC2_SRA = 1'b1;

    localparam int ALU_NUM_OPS = 12;
    localparam int ALU_SEL_W   = $clog2(ALU_NUM_OPS);

    localparam logic [ALU_SEL_W-1:0] ALU_ADD      = 4'd0;
    localparam logic [ALU_SEL_W-1:0] ALU_SUB      = 4'd1;
    localparam logic [ALU_SEL_W-1:0] ALU_AND      = 4'd2;
    localparam logic [ALU_SEL_W-1:0] ALU_OR       = 4'd3;
    localparam logic [ALU_SEL_W-1:0] ALU_XOR      = 4'd4;
    localparam logic [ALU_SEL_W-1:0] ALU_SLL      = 4'd5;
    localparam logic [ALU_SEL_W-1:0] ALU_SRL      = 4'd6;
    localparam logic [ALU_SEL_W-1:0] ALU_SRA      = 4'd7;
    localparam logic [ALU_SEL_W-1:0] ALU_SLT      = 4'd8;
    localparam logic [ALU_SEL_W-1:0] ALU_SLTU     = 4'd9;
    localparam logic [ALU_SEL_W-1:0] ALU_A_PLUS_4 = 4'd10;
    localparam logic [ALU_SEL_W-1:0] ALU_BSEL     = 4'd11;

    localparam logic A_REG   = 1'b0;
    localparam logic A_PC    = 1'b1;
    localparam logic B_REG   = 1'b0;
    localparam logic B_IMM   = 1'b1;
    localparam logic CSR_RD1 = 1'b0;
    localparam logic CSR_IMM = 1'b1;

    localparam logic [1:0] MEM_SIZE_BYTE = 2'd0;
    localparam logic [1:0] MEM_SIZE_HALF = 2'd1;
    localparam logic [1:0] MEM_SIZE_WORD = 2'd2;
    localparam logic [1:0] MEM_SIZE_NONE = 2'd3;

    // Top nibble of the address
    localparam logic [3:0] ADDR_DMEM   = 4'b0001;
    localparam logic [3:0] ADDR_IMEM   = 4'b0010;
    localparam logic [3:0] ADDR_MIRROR = 4'b0011;
    localparam logic [3:0] ADDR_BIOS   = 4'b0100;
    localparam logic [3:0] ADDR_IO     = 4'b1000;

    localparam logic [ALU_SEL_W-1:0] ALU_DONT_CARE = ALU_ADD;
    localparam logic A_DONT_CARE    = A_REG;
    localparam logic B_DONT_CARE    = B_REG;
    localparam logic CSR_DONT_CARE  = CSR_RD1;
    localparam logic BRUN_DONT_CARE = 1'b0;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        u_fmt_t u_fmt;
    } inst_t;

endpackage

//--- verilog/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    input  logic [31:0] rs1,
    input  logic [31:0] rs2,
    input  logic        br_taken,
    output logic [31:0] alu_out,
    output logic        flush,
    output logic        br_suc,
    output logic        br_inst,
    output logic        csr_en,
    output logic [31:0] csr_wdata,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    output logic [3:0]  mem_wmask,
    output logic        imem_en,
    output logic        dmem_en,
    output logic        bios_en,
    output logic        io_en
);
    import ex_pkg::*;

    inst_t                inst_w;
    logic [31:0]          imm;
    logic [31:0]          op_a;
    logic [31:0]          op_b;
    logic [31:0]          addr;
    logic [ALU_SEL_W-1:0] alu_sel;
    logic [1:0]           size;
    logic                 brun;
    logic                 breq;
    logic                 brlt;
    logic                 a_sel;
    logic                 b_sel;
    logic                 csr_mux_sel;
    logic                 imem_en_d;
    logic                 dmem_en_d;
    logic                 bios_en_d;
    logic                 io_en_d;

    assign inst_w = inst;

    assign op_a    = (a_sel == A_PC) ? pc : rs1;
    assign op_b    = (b_sel == B_IMM) ? imm : rs2;
    assign alu_out = addr;

    // CSRRWI carries its immediate in the rs1 field
    assign csr_wdata = (csr_mux_sel == CSR_IMM) ? {27'b0, inst_w.r_fmt.rs1} : rs1;

    ex_control u_ex_control (
        .inst        (inst_w),
        .addr        (addr),
        .pc          (pc),
        .breq        (breq),
        .brlt        (brlt),
        .br_taken    (br_taken),
        .alu_sel     (alu_sel),
        .size        (size),
        .brun        (brun),
        .a_sel       (a_sel),
        .b_sel       (b_sel),
        .csr_mux_sel (csr_mux_sel),
        .csr_en      (csr_en),
        .br_suc      (br_suc),
        .flush       (flush),
        .br_inst     (br_inst),
        .imem_en     (imem_en_d),
        .dmem_en     (dmem_en_d),
        .bios_en     (bios_en_d),
        .io_en       (io_en_d)
    );

    imm_gen u_imm_gen (
        .inst (inst_w),
        .imm  (imm)
    );

    ex_alu u_ex_alu (
        .a       (op_a),
        .b       (op_b),
        .alu_sel (alu_sel),
        .rs1     (rs1),
        .rs2     (rs2),
        .brun    (brun),
        .result  (addr),
        .breq    (breq),
        .brlt    (brlt)
    );

    mem_req_reg u_mem_req_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (addr),
        .store_data (rs2),
        .size       (size),
        .imem_en    (imem_en_d),
        .dmem_en    (dmem_en_d),
        .bios_en    (bios_en_d),
        .io_en      (io_en_d),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_wmask  (mem_wmask),
        .imem_en_q  (imem_en),
        .dmem_en_q  (dmem_en),
        .bios_en_q  (bios_en),
        .io_en_q    (io_en)
    );

endmodule

//--- verilog/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  ex_pkg::inst_t inst,
    output logic [31:0]   imm
);
    import ex_pkg::*;

    logic [4:0] opcode5;

    assign opcode5 = inst.r_fmt.opcode[6:2];

    always_comb begin
        case (opcode5)
            OPC_ARI_ITYPE, OPC_LOAD, OPC_JALR: begin
                imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
            end
            OPC_STORE: begin
                imm = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
            end
            // B-type reuses the S layout with bits shuffled
            OPC_BRANCH: begin
                imm = {{19{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi[6],
                       inst.s_fmt.imm_lo[0], inst.s_fmt.imm_hi[5:0],
                       inst.s_fmt.imm_lo[4:1], 1'b0};
            end
            OPC_LUI, OPC_AUIPC: begin
                imm = {inst.u_fmt.imm, 12'b0};
            end
            OPC_JAL: begin
                imm = {{11{inst.u_fmt.imm[19]}}, inst.u_fmt.imm[19],
                       inst.u_fmt.imm[7:0], inst.u_fmt.imm[8],
                       inst.u_fmt.imm[18:9], 1'b0};
            end
            default: begin
                imm = 32'b0;
            end
        endcase
    end

endmodule

//--- verilog/mem_req_reg.sv
`timescale 1ns/1ps

module mem_req_reg (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] addr,
    input  logic [31:0] store_data,
    input  logic [1:0]  size,
    input  logic        imem_en,
    input  logic        dmem_en,
    input  logic        bios_en,
    input  logic        io_en,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    output logic [3:0]  mem_wmask,
    output logic        imem_en_q,
    output logic        dmem_en_q,
    output logic        bios_en_q,
    output logic        io_en_q
);
    import ex_pkg::*;

    logic [3:0]  wmask_d;
    logic [31:0] wdata_d;

    always_comb begin
        case (size)
            MEM_SIZE_BYTE: begin
                wmask_d = 4'b0001 << addr[1:0];
                wdata_d = {24'b0, store_data[7:0]} << {addr[1:0], 3'b000};
            end
            MEM_SIZE_HALF: begin
                wmask_d = addr[1] ? 4'b1100 : 4'b0011;
                wdata_d = {16'b0, store_data[15:0]} << {addr[1], 4'b0000};
            end
            MEM_SIZE_WORD: begin
                wmask_d = 4'b1111;
                wdata_d = store_data;
            end
            // No write, loads and non-memory ops
            default: begin
                wmask_d = 4'b0000;
                wdata_d = store_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_addr  <= 32'b0;
            mem_wdata <= 32'b0;
            mem_wmask <= 4'b0;
            imem_en_q <= 1'b0;
            dmem_en_q <= 1'b0;
            bios_en_q <= 1'b0;
            io_en_q   <= 1'b0;
        end else begin
            mem_addr  <= addr;
            mem_wdata <= wdata_d;
            mem_wmask <= wmask_d;
            imem_en_q <= imem_en;
            dmem_en_q <= dmem_en;
            bios_en_q <= bios_en;
            io_en_q   <= io_en;
        end
    end

endmodule
